// File: list.f
+incdir+source
source/mult_types_pkg.sv
source/mem_types_pkg.sv
source/res_wr_if.sv
source/loa_adder.sv
source/split_multiplier.sv
source/mult_lane.sv
source/result_arbiter.sv
source/result_mem.sv
source/approx_mult_top.sv
testbench/tb_approx_mult.sv

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module tb_approx_mult -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -q "TEST OK" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// File: source/approx_mult_top.sv
`timescale 1ns/1ps
`include "mult_defines.svh"

module approx_mult_top (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     lane0_strobe,
    input  mult_types_pkg::operand_t lane0_a,
    input  mult_types_pkg::operand_t lane0_b,
    input  mem_types_pkg::res_addr_t lane0_addr,
    input  logic                     lane1_strobe,
    input  mult_types_pkg::operand_t lane1_a,
    input  mult_types_pkg::operand_t lane1_b,
    input  mem_types_pkg::res_addr_t lane1_addr,
    input  logic                     rd_strobe,
    input  mem_types_pkg::res_addr_t rd_addr,
    output logic                     rd_valid,
    output mult_types_pkg::product_t rd_data,
    output logic                     commit_strobe,
    output mem_types_pkg::res_addr_t commit_addr,
    output mem_types_pkg::lane_id_t  commit_lane
);
    import mult_types_pkg::*;
    import mem_types_pkg::*;

    logic      we;
    res_addr_t waddr;
    product_t  wdata;

    res_wr_if lane0_wr ();
    res_wr_if lane1_wr ();

    mult_lane #(
        .APPROX_BITS (0)
    ) i_lane_exact (
        .clk    (clk),
        .arst_n (arst_n),
        .strobe (lane0_strobe),
        .a      (lane0_a),
        .b      (lane0_b),
        .addr   (lane0_addr),
        .wr     (lane0_wr.lane)
    );

    mult_lane #(
        .APPROX_BITS (`LOA_BITS)
    ) i_lane_approx (
        .clk    (clk),
        .arst_n (arst_n),
        .strobe (lane1_strobe),
        .a      (lane1_a),
        .b      (lane1_b),
        .addr   (lane1_addr),
        .wr     (lane1_wr.lane)
    );

    result_arbiter i_result_arbiter (
        .clk           (clk),
        .arst_n        (arst_n),
        .req0          (lane0_wr.arbiter),
        .req1          (lane1_wr.arbiter),
        .we            (we),
        .waddr         (waddr),
        .wdata         (wdata),
        .commit_strobe (commit_strobe),
        .commit_addr   (commit_addr),
        .commit_lane   (commit_lane)
    );

    result_mem i_result_mem (
        .clk       (clk),
        .arst_n    (arst_n),
        .we        (we),
        .waddr     (waddr),
        .wdata     (wdata),
        .rd_strobe (rd_strobe),
        .rd_addr   (rd_addr),
        .rd_valid  (rd_valid),
        .rd_data   (rd_data)
    );

endmodule

// File: source/loa_adder.sv
`timescale 1ns/1ps

// needs A_W >= B_W and APPROX_BITS < A_W.
module loa_adder #(
    parameter int A_W         = 12,
    parameter int B_W         = 9,
    parameter int APPROX_BITS = 0
) (
    input  logic [A_W-1:0] a,
    input  logic [B_W-1:0] b,
    output logic [A_W:0]   sum
);
    localparam int HI_W = A_W - APPROX_BITS;

    logic [A_W-1:0] b_ext;

    assign b_ext = A_W'(b);  // zero extend.

    generate
        if (APPROX_BITS == 0) begin : g_exact
            assign sum = {1'b0, a} + {1'b0, b_ext};
        end else begin : g_loa
            logic [APPROX_BITS-1:0] low_or;
            logic [HI_W:0]          high_sum;

            assign low_or   = a[APPROX_BITS-1:0] | b_ext[APPROX_BITS-1:0];  // no carry out.
            assign high_sum = {1'b0, a[A_W-1:APPROX_BITS]} + {1'b0, b_ext[A_W-1:APPROX_BITS]};
            assign sum      = {high_sum, low_or};
        end
    endgenerate

endmodule

// File: source/mem_types_pkg.sv
`include "mult_defines.svh"

package mem_types_pkg;

    localparam int RES_ADDR_W = $clog2(`RES_DEPTH);

    // address of one result entry.
    typedef logic [RES_ADDR_W-1:0] res_addr_t;

    // lane number carried with every result.
    typedef logic lane_id_t;

    localparam lane_id_t LANE_EXACT  = 1'b0;
    localparam lane_id_t LANE_APPROX = 1'b1;

endpackage

// File: source/mult_defines.svh
`ifndef MULT_DEFINES_SVH
`define MULT_DEFINES_SVH

// operand width of both lanes.
`define MULT_W 8

// low bits ORed in the approximate lane.
`define LOA_BITS 3

// result memory entries.
`define RES_DEPTH 16

`endif

// File: source/mult_lane.sv
`timescale 1ns/1ps

module mult_lane #(
    parameter int APPROX_BITS = 0
) (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     strobe,
    input  mult_types_pkg::operand_t a,
    input  mult_types_pkg::operand_t b,
    input  mem_types_pkg::res_addr_t addr,
    res_wr_if.lane                   wr
);
    import mult_types_pkg::*;
    import mem_types_pkg::*;

    localparam lane_id_t LANE_ID = (APPROX_BITS == 0) ? LANE_EXACT : LANE_APPROX;

    logic      s1_valid;
    operand_t  s1_a;
    operand_t  s1_b;
    res_addr_t s1_addr;
    product_t  s1_prod;

    split_multiplier #(
        .APPROX_BITS (APPROX_BITS)
    ) i_split_multiplier (
        .a (s1_a),
        .b (s1_b),
        .p (s1_prod)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid <= 1'b0;
            wr.valid <= 1'b0;
        end else begin
            s1_valid <= strobe;
            wr.valid <= s1_valid;  // request two edges after strobe.
        end
    end

    always_ff @(posedge clk) begin
        if (strobe) begin
            s1_a    <= a;
            s1_b    <= b;
            s1_addr <= addr;
        end
        if (s1_valid) begin
            wr.data <= s1_prod;
            wr.addr <= s1_addr;
        end
    end

    assign wr.lane_id = LANE_ID;

    // host may strobe a lane at most every other cycle.
    a_strobe_spacing: assert property (@(posedge clk) disable iff (!arst_n)
        strobe |=> !strobe);

endmodule

// File: source/mult_types_pkg.sv
`include "mult_defines.svh"

package mult_types_pkg;

    // operands are split in two equal halves.
    localparam int HALF_W = `MULT_W / 2;

    // unsigned multiplier operand.
    typedef logic [`MULT_W-1:0] operand_t;

    // high or low half of an operand.
    typedef logic [HALF_W-1:0] half_t;

    // full width product.
    typedef logic [2*`MULT_W-1:0] product_t;

endpackage

// File: source/res_wr_if.sv
`timescale 1ns/1ps

interface res_wr_if;
    import mult_types_pkg::*;
    import mem_types_pkg::*;

    logic      valid;    // one cycle, never refused.
    res_addr_t addr;
    product_t  data;
    lane_id_t  lane_id;

    modport lane (output valid, addr, data, lane_id);
    modport arbiter (input valid, addr, data, lane_id);
endinterface

// File: source/result_arbiter.sv
`timescale 1ns/1ps

module result_arbiter (
    input  logic                     clk,
    input  logic                     arst_n,
    res_wr_if.arbiter                req0,
    res_wr_if.arbiter                req1,
    output logic                     we,
    output mem_types_pkg::res_addr_t waddr,
    output mult_types_pkg::product_t wdata,
    output logic                     commit_strobe,
    output mem_types_pkg::res_addr_t commit_addr,
    output mem_types_pkg::lane_id_t  commit_lane
);
    import mult_types_pkg::*;
    import mem_types_pkg::*;

    logic      req_v     [2];
    res_addr_t req_addr  [2];
    product_t  req_data  [2];
    lane_id_t  req_lane  [2];

    logic      hold_v    [2];
    res_addr_t hold_addr [2];
    product_t  hold_data [2];
    lane_id_t  hold_lane [2];

    logic prio;  // port that wins a tie.
    logic gnt;

    assign req_v[0]    = req0.valid;
    assign req_addr[0] = req0.addr;
    assign req_data[0] = req0.data;
    assign req_lane[0] = req0.lane_id;
    assign req_v[1]    = req1.valid;
    assign req_addr[1] = req1.addr;
    assign req_data[1] = req1.data;
    assign req_lane[1] = req1.lane_id;

    always_comb begin
        if (hold_v[0] && hold_v[1]) begin
            gnt = prio;
        end else begin
            gnt = hold_v[1];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hold_v[0] <= 1'b0;
            hold_v[1] <= 1'b0;
            prio      <= 1'b0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (req_v[i]) begin
                    hold_v[i] <= 1'b1;  // new request beats the clear.
                end else if (we && int'(gnt) == i) begin
                    hold_v[i] <= 1'b0;
                end
            end
            if (we) begin
                prio <= ~gnt;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < 2; i++) begin
            if (req_v[i]) begin
                hold_addr[i] <= req_addr[i];
                hold_data[i] <= req_data[i];
                hold_lane[i] <= req_lane[i];
            end
        end
    end

    assign we            = hold_v[0] | hold_v[1];
    assign waddr         = hold_addr[gnt];
    assign wdata         = hold_data[gnt];
    assign commit_strobe = we;
    assign commit_addr   = hold_addr[gnt];
    assign commit_lane   = hold_lane[gnt];

    // a full hold must drain in the same cycle a new request lands.
    for (genvar g = 0; g < 2; g++) begin : g_hold_chk
        a_no_overwrite: assert property (@(posedge clk) disable iff (!arst_n)
            req_v[g] |-> !hold_v[g] || gnt == 1'(g));
    end

endmodule

// File: source/result_mem.sv
`timescale 1ns/1ps
`include "mult_defines.svh"

module result_mem (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     we,
    input  mem_types_pkg::res_addr_t waddr,
    input  mult_types_pkg::product_t wdata,
    input  logic                     rd_strobe,
    input  mem_types_pkg::res_addr_t rd_addr,
    output logic                     rd_valid,
    output mult_types_pkg::product_t rd_data
);
    import mult_types_pkg::*;

    product_t mem [`RES_DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_strobe) begin
            rd_data <= mem[rd_addr];  // old data on same-address write.
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_strobe;
        end
    end

endmodule

// File: source/split_multiplier.sv
`timescale 1ns/1ps

module split_multiplier #(
    parameter int APPROX_BITS = 0
) (
    input  mult_types_pkg::operand_t a,
    input  mult_types_pkg::operand_t b,
    output mult_types_pkg::product_t p
);
    import mult_types_pkg::*;

    localparam int PP_W = 2 * HALF_W;  // partial product width.

    half_t a_hi;
    half_t a_lo;
    half_t b_hi;
    half_t b_lo;

    logic [PP_W-1:0] p_hh;
    logic [PP_W-1:0] p_hl;
    logic [PP_W-1:0] p_lh;
    logic [PP_W-1:0] p_ll;

    logic [PP_W:0]          mid_sum;   // exact cross term.
    logic [PP_W+HALF_W-1:0] upper_op;
    logic [PP_W+HALF_W:0]   final_sum;

    assign {a_hi, a_lo} = a;
    assign {b_hi, b_lo} = b;

    assign p_hh = PP_W'(a_hi) * PP_W'(b_hi);
    assign p_hl = PP_W'(a_hi) * PP_W'(b_lo);
    assign p_lh = PP_W'(a_lo) * PP_W'(b_hi);
    assign p_ll = PP_W'(a_lo) * PP_W'(b_lo);

    loa_adder #(
        .A_W         (PP_W),
        .B_W         (PP_W),
        .APPROX_BITS (0)
    ) i_mid_adder (
        .a   (p_hl),
        .b   (p_lh),
        .sum (mid_sum)
    );

    assign upper_op = {p_hh, p_ll[PP_W-1:HALF_W]};

    loa_adder #(
        .A_W         (PP_W + HALF_W),
        .B_W         (PP_W + 1),
        .APPROX_BITS (APPROX_BITS)
    ) i_final_adder (
        .a   (upper_op),
        .b   (mid_sum),
        .sum (final_sum)
    );

    // top sum bit never set for 8x8 operands.
    assign p = {final_sum[PP_W+HALF_W-1:0], p_ll[HALF_W-1:0]};

endmodule

// File: testbench/tb_approx_mult.sv
`timescale 1ns/1ps
`include "mult_defines.svh"

module tb_approx_mult;
    import mult_types_pkg::*;
    import mem_types_pkg::*;

    localparam int NUM_ROWS      = 16;
    localparam int NUM_FIXED     = 10;
    localparam int WAIT_LIMIT    = 20;

    typedef struct packed {
        lane_id_t  lane;
        operand_t  a;
        operand_t  b;
        res_addr_t addr;
        logic      pair;     // strobed together with the next row.
        logic      collide;  // low LOA bits overlap.
        product_t  expected;
    } row_t;

    logic      clk;
    logic      arst_n;
    logic      lane0_strobe;
    operand_t  lane0_a;
    operand_t  lane0_b;
    res_addr_t lane0_addr;
    logic      lane1_strobe;
    operand_t  lane1_a;
    operand_t  lane1_b;
    res_addr_t lane1_addr;
    logic      rd_strobe;
    res_addr_t rd_addr;
    logic      rd_valid;
    product_t  rd_data;
    logic      commit_strobe;
    res_addr_t commit_addr;
    lane_id_t  commit_lane;

    row_t     rows [NUM_ROWS];
    int       error_count   = 0;
    int       timeout_count = 0;
    lane_id_t last_lane     = LANE_APPROX;  // so lane 0 wins the first tie.

    approx_mult_top i_approx_mult_top (
        .clk           (clk),
        .arst_n        (arst_n),
        .lane0_strobe  (lane0_strobe),
        .lane0_a       (lane0_a),
        .lane0_b       (lane0_b),
        .lane0_addr    (lane0_addr),
        .lane1_strobe  (lane1_strobe),
        .lane1_a       (lane1_a),
        .lane1_b       (lane1_b),
        .lane1_addr    (lane1_addr),
        .rd_strobe     (rd_strobe),
        .rd_addr       (rd_addr),
        .rd_valid      (rd_valid),
        .rd_data       (rd_data),
        .commit_strobe (commit_strobe),
        .commit_addr   (commit_addr),
        .commit_lane   (commit_lane)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // split operands, four partial products, k low bits ORed in the final add.
    function automatic product_t ref_product(input operand_t a, input operand_t b, input int k);
        logic [7:0]  p_hh;
        logic [7:0]  p_hl;
        logic [7:0]  p_lh;
        logic [7:0]  p_ll;
        logic [11:0] mid;
        logic [11:0] op_hi;
        logic [11:0] low_mask;
        logic [11:0] sum;
        p_hh     = {4'b0, a[7:4]} * {4'b0, b[7:4]};
        p_hl     = {4'b0, a[7:4]} * {4'b0, b[3:0]};
        p_lh     = {4'b0, a[3:0]} * {4'b0, b[7:4]};
        p_ll     = {4'b0, a[3:0]} * {4'b0, b[3:0]};
        mid      = {4'b0, p_hl} + {4'b0, p_lh};
        op_hi    = {p_hh, p_ll[7:4]};
        low_mask = (12'd1 << k) - 12'd1;
        sum      = (((op_hi >> k) + (mid >> k)) << k) | ((op_hi | mid) & low_mask);
        return {sum, p_ll[3:0]};
    endfunction

    task automatic report_mismatch(input string msg);
        $display("Fail %0t: %s", $time, msg);
        error_count++;
    endtask

    task automatic set_row(input int idx, input lane_id_t lane, input operand_t a,
                           input operand_t b, input res_addr_t addr, input logic pair,
                           input logic collide);
        rows[idx] = '{lane, a, b, addr, pair, collide,
                      ref_product(a, b, (lane == LANE_APPROX) ? `LOA_BITS : 0)};
    endtask

    task automatic fill_table();
        set_row(0, LANE_EXACT, 8'h00, 8'h5a, 4'd0, 1'b0, 1'b0);
        set_row(1, LANE_EXACT, 8'hff, 8'hff, 4'd1, 1'b0, 1'b0);
        set_row(2, LANE_APPROX, 8'hff, 8'hff, 4'd2, 1'b0, 1'b1);
        set_row(3, LANE_APPROX, 8'h2f, 8'h2f, 4'd3, 1'b0, 1'b1);
        set_row(4, LANE_APPROX, 8'h33, 8'h33, 4'd4, 1'b0, 1'b0);
        set_row(5, LANE_EXACT, 8'h12, 8'h34, 4'd5, 1'b1, 1'b0);
        set_row(6, LANE_APPROX, 8'h9c, 8'he7, 4'd6, 1'b0, 1'b0);
        set_row(7, LANE_EXACT, 8'hc3, 8'h3c, 4'd1, 1'b0, 1'b0);   // overwrites addr 1.
        set_row(8, LANE_APPROX, 8'h47, 8'hb5, 4'd7, 1'b1, 1'b0);
        set_row(9, LANE_EXACT, 8'h80, 8'h02, 4'd8, 1'b0, 1'b0);
        void'($urandom(32'haf14));
        for (int i = NUM_FIXED; i < NUM_ROWS; i++) begin
            set_row(i, lane_id_t'(i % 2), operand_t'($urandom), operand_t'($urandom),
                    res_addr_t'(i), 1'b0, 1'b0);
        end
    endtask

    task automatic drive_lane(input row_t r);
        if (r.lane == LANE_EXACT) begin
            lane0_strobe <= 1'b1;
            lane0_a      <= r.a;
            lane0_b      <= r.b;
            lane0_addr   <= r.addr;
        end else begin
            lane1_strobe <= 1'b1;
            lane1_a      <= r.a;
            lane1_b      <= r.b;
            lane1_addr   <= r.addr;
        end
    endtask

    task automatic wait_commit(output lane_id_t lane, output res_addr_t addr,
                               output int cycles, output logic seen);
        cycles = 0;
        lane   = LANE_EXACT;
        addr   = '0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!commit_strobe && cycles < WAIT_LIMIT);
        seen = commit_strobe;
        if (!seen) begin
            $display("timeout: no commit_strobe within %0d cycles", WAIT_LIMIT);
            timeout_count++;
        end else begin
            lane = commit_lane;
            addr = commit_addr;
        end
    endtask

    task automatic read_back(input res_addr_t addr, output product_t data, output logic seen);
        int cycles;
        @(posedge clk);
        rd_strobe <= 1'b1;
        rd_addr   <= addr;
        @(negedge clk);
        assert (!rd_valid) else report_mismatch("rd_valid high before the strobe was taken");
        @(posedge clk);
        rd_strobe <= 1'b0;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!rd_valid && cycles < WAIT_LIMIT);
        seen = rd_valid;
        data = rd_data;
        if (!seen) begin
            $display("timeout: no rd_valid within %0d cycles", WAIT_LIMIT);
            timeout_count++;
        end else begin
            assert (cycles == 1) else report_mismatch($sformatf("rd_valid late by %0d", cycles));
            @(negedge clk);
            assert (!rd_valid) else report_mismatch("rd_valid longer than one cycle");
        end
    endtask

    task automatic check_result(input int idx);
        product_t data;
        logic     seen;
        read_back(rows[idx].addr, data, seen);
        if (seen) begin
            assert (data == rows[idx].expected) else report_mismatch($sformatf(
                "row %0d addr %0d read %0d expected %0d", idx, rows[idx].addr, data,
                rows[idx].expected));
            if (rows[idx].collide) begin
                assert (data != ref_product(rows[idx].a, rows[idx].b, 0))
                    else report_mismatch($sformatf("row %0d approx equals exact", idx));
            end
        end
    endtask

    task automatic check_commit(input int idx, input lane_id_t lane, input res_addr_t addr);
        assert (lane == rows[idx].lane && addr == rows[idx].addr) else report_mismatch(
            $sformatf("commit lane %0d addr %0d, expected row %0d", lane, addr, idx));
        last_lane = rows[idx].lane;
    endtask

    task automatic run_single(input int idx);
        lane_id_t  lane;
        res_addr_t addr;
        int        cycles;
        logic      seen;
        @(posedge clk);
        drive_lane(rows[idx]);
        @(posedge clk);
        lane0_strobe <= 1'b0;
        lane1_strobe <= 1'b0;
        wait_commit(lane, addr, cycles, seen);
        if (seen) begin
            assert (cycles == 3) else report_mismatch(
                $sformatf("commit %0d cycles after strobe, expected 3", cycles));
            check_commit(idx, lane, addr);
        end
        check_result(idx);
    endtask

    task automatic run_pair(input int idx);
        lane_id_t  lane;
        res_addr_t addr;
        int        cycles;
        logic      seen;
        int        first;
        @(posedge clk);
        drive_lane(rows[idx]);
        drive_lane(rows[idx+1]);
        @(posedge clk);
        lane0_strobe <= 1'b0;
        lane1_strobe <= 1'b0;
        first = (rows[idx].lane == lane_id_t'(~last_lane)) ? idx : idx + 1;  // loser of last grant.
        wait_commit(lane, addr, cycles, seen);
        if (seen) begin
            assert (cycles == 3) else report_mismatch(
                $sformatf("first commit %0d cycles after strobe, expected 3", cycles));
            check_commit(first, lane, addr);
            wait_commit(lane, addr, cycles, seen);
            if (seen) begin
                assert (cycles == 1) else report_mismatch("second commit not back to back");
                check_commit((first == idx) ? idx + 1 : idx, lane, addr);
            end
        end
        check_result(idx);
        check_result(idx + 1);
    endtask

    initial begin
        int i;
        arst_n       <= 1'b0;
        lane0_strobe <= 1'b0;
        lane0_a      <= '0;
        lane0_b      <= '0;
        lane0_addr   <= '0;
        lane1_strobe <= 1'b0;
        lane1_a      <= '0;
        lane1_b      <= '0;
        lane1_addr   <= '0;
        rd_strobe    <= 1'b0;
        rd_addr      <= '0;
        fill_table();
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        repeat (5) begin
            @(negedge clk);
            assert (!commit_strobe && !rd_valid) else report_mismatch("activity while idle");
        end
        i = 0;
        while (i < NUM_ROWS) begin
            if (rows[i].pair) begin
                run_pair(i);
                i += 2;
            end else begin
                run_single(i);
                i += 1;
            end
        end
        $display("errors: %0d, timeouts: %0d", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
